//--- verilog.f
dmaBusPkg.sv
dmaRegPkg.sv
dmaRegisterFile.sv
dmaPriorityLogic.sv
dmaTimingControl.sv
dmaController.sv
dmaControllerTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = dmaControllerTb
FILELIST = verilog.f
LOG      = sim.log

BIN  = obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "Simulation FAILED" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Simulation FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dmaControllerTb.sv
`timescale 1ns/10ps

module dmaControllerTb;

  localparam int numRows = 5;
  localparam int phaseIdle = 0;
  localparam int phaseS1 = 1;
  localparam int phaseS2 = 2;
  localparam int phaseS4 = 3;

  typedef struct packed {
    logic valid;
    dmaRegPkg::channelIdxT chan;
    logic [15:0] base;
    logic [15:0] count;
    dmaRegPkg::transferTypeT xferType;
  } chanSetupT;

  // setup[1] sits above setup[0] in the packed row.
  typedef struct packed {
    logic [3:0] reqMask;
    logic [1:0] hldaDelay;
    chanSetupT [1:0] setup;
  } scenarioT;

  localparam chanSetupT noSetup = '0;

  logic TCbusIf;
  logic rst;
  dmaBusPkg::cpuBusT cpuBus;
  logic [3:0] dreq;
  logic hlda;
  logic hrq;
  logic [3:0] dack;
  dmaBusPkg::sysBusT sysBus;

  scenarioT scenarios [numRows];
  int seed;
  int busErrors;
  int dackErrors;
  int hrqErrors;
  int otherErrors;
  longint watchdogNs;
  logic tableReady;

  dmaController dmaController_inst (
    .TCbusIf (TCbusIf),
    .rst     (rst),
    .cpuBus  (cpuBus),
    .dreq    (dreq),
    .hlda    (hlda),
    .hrq     (hrq),
    .dack    (dack),
    .sysBus  (sysBus)
  );

  always
  begin
    TCbusIf = 1'b0;
    #50;
    TCbusIf = 1'b1;
    #50;
  end

  function automatic chanSetupT makeSetup(input int chan, input logic [15:0] base,
      input logic [15:0] count, input dmaRegPkg::transferTypeT xferType);
    chanSetupT s;
    s.valid = 1'b1;
    s.chan = dmaRegPkg::channelIdxT'(chan);
    s.base = base;
    s.count = count;
    s.xferType = xferType;
    return s;
  endfunction

  // pins expected in each phase of one transfer.
  function automatic dmaBusPkg::sysBusT expectBus(input int phase, input logic [15:0] addr,
      input dmaRegPkg::transferTypeT xferType, input logic last);
    dmaBusPkg::sysBusT expected;
    expected = '0;
    expected.iorN = !(phase == phaseS2 && xferType == dmaRegPkg::writeXfer);
    expected.memwN = !(phase == phaseS2 && xferType == dmaRegPkg::writeXfer);
    expected.iowN = !(phase == phaseS2 && xferType == dmaRegPkg::readXfer);
    expected.memrN = !(phase == phaseS2 && xferType == dmaRegPkg::readXfer);
    expected.eopN = !(phase == phaseS4 && last);
    expected.adstb = (phase == phaseS1);
    if (phase == phaseS1 || phase == phaseS2)
    begin
      expected.aen = 1'b1;
      expected.address = addr;  // the bus only carries an address while aen is high.
    end
    return expected;
  endfunction

  function automatic int lowestRequest(input logic [3:0] mask);
    int pick;
    pick = -1;
    for (int i = 0; i < 4; i++)
      if (mask[i] && pick < 0)
        pick = i;
    return pick;
  endfunction

  task automatic checkBus(input string where, input dmaBusPkg::sysBusT expected,
      input dmaBusPkg::sysBusT actual);
    if (actual !== expected)
    begin
      busErrors++;
      $display("Error at %0d ns: sysBus in %s expected %h actual %h",
        $time, where, expected, actual);
    end
  endtask

  task automatic checkDack(input string where, input logic [3:0] expected,
      input logic [3:0] actual);
    if (actual !== expected)
    begin
      dackErrors++;
      $display("Error at %0d ns: dack in %s expected %b actual %b",
        $time, where, expected, actual);
    end
  endtask

  task automatic checkHrq(input string where, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      hrqErrors++;
      $display("Error at %0d ns: hrq in %s expected %b actual %b",
        $time, where, expected, actual);
    end
  endtask

  // no bus cycle running, with hrq either idle low or held high in request.
  task automatic checkNoBus(input string where, input logic expectHrq);
    checkHrq(where, expectHrq, hrq);
    checkDack(where, 4'b0000, dack);
    checkBus(where, expectBus(phaseIdle, 16'h0000, dmaRegPkg::verifyXfer, 1'b0), sysBus);
  endtask

  task automatic writeReg(input logic [4:0] regAddr, input logic [7:0] data);
    @(posedge TCbusIf);
    #5;
    cpuBus.csN = 1'b0;
    cpuBus.wrN = 1'b0;
    cpuBus.regAddr = regAddr;
    cpuBus.data = data;
  endtask

  task automatic releaseCpu();
    @(posedge TCbusIf);
    #5;
    cpuBus.csN = 1'b1;
    cpuBus.wrN = 1'b1;
  endtask

  task automatic programChannel(input chanSetupT s);
    writeReg({1'b0, s.chan, dmaRegPkg::fieldAddrLow}, s.base[7:0]);
    writeReg({1'b0, s.chan, dmaRegPkg::fieldAddrHigh}, s.base[15:8]);
    writeReg({1'b0, s.chan, dmaRegPkg::fieldCountLow}, s.count[7:0]);
    writeReg({1'b0, s.chan, dmaRegPkg::fieldCountHigh}, s.count[15:8]);
    writeReg(5'b10000, {4'b0000, s.xferType, s.chan});
  endtask

  task automatic serveTransfer(input int ch, input logic [15:0] addr,
      input dmaRegPkg::transferTypeT xferType, input logic last, input logic [1:0] delay);
    logic [3:0] chDack;
    logic seen;
    chDack = 4'b0001 << ch;
    seen = 1'b0;
    for (int i = 0; i < 12 && !seen; i++)
    begin
      @(negedge TCbusIf);
      if (hrq === 1'b1)
        seen = 1'b1;
      else
        checkNoBus("idle", 1'b0);
    end
    if (!seen)
    begin
      otherErrors++;
      $display("hrq never rose while channel %0d was requesting.", ch);
      return;
    end
    // the host holds off, so the controller has to sit in request.
    repeat (delay)
    begin
      checkNoBus("request", 1'b1);
      @(negedge TCbusIf);
    end
    checkNoBus("request", 1'b1);
    @(posedge TCbusIf);
    #5;
    hlda = 1'b1;
    @(negedge TCbusIf);
    checkNoBus("request", 1'b1);
    @(negedge TCbusIf);
    checkHrq("S1", 1'b1, hrq);
    checkDack("S1", chDack, dack);
    checkBus("S1", expectBus(phaseS1, addr, xferType, last), sysBus);
    @(negedge TCbusIf);
    checkHrq("S2", 1'b1, hrq);
    checkDack("S2", chDack, dack);
    checkBus("S2", expectBus(phaseS2, addr, xferType, last), sysBus);
    @(negedge TCbusIf);
    checkHrq("S4", 1'b0, hrq);
    checkDack("S4", 4'b0000, dack);
    checkBus("S4", expectBus(phaseS4, addr, xferType, last), sysBus);
    @(posedge TCbusIf);
    #5;
    hlda = 1'b0;
  endtask

  task automatic runScenario(input scenarioT sc);
    logic [3:0] pending;
    logic [15:0] baseOf [4];
    logic [15:0] countOf [4];
    dmaRegPkg::transferTypeT typeOf [4];
    int ch;
    for (int j = 0; j < 2; j++)
    begin
      if (sc.setup[j].valid)
      begin
        programChannel(sc.setup[j]);
        baseOf[sc.setup[j].chan] = sc.setup[j].base;
        countOf[sc.setup[j].chan] = sc.setup[j].count;
        typeOf[sc.setup[j].chan] = sc.setup[j].xferType;
      end
    end
    releaseCpu();
    dreq = sc.reqMask;
    pending = sc.reqMask;
    while (pending != 4'b0000)
    begin
      ch = lowestRequest(pending);
      for (int k = 0; k < int'(countOf[ch]); k++)
        serveTransfer(ch, baseOf[ch] + 16'(k), typeOf[ch], k == int'(countOf[ch]) - 1,
          sc.hldaDelay);
      pending[ch] = 1'b0;
      dreq = pending;  // the served peripheral drops its request after EOP.
      if (pending != 4'b0000)
      begin
        ch = lowestRequest(pending);
        writeReg(5'b10000, {4'b0000, typeOf[ch], dmaRegPkg::channelIdxT'(ch)});
        releaseCpu();
      end
    end
    // after terminal count the controller waits for a register write.
    dreq = sc.reqMask;
    repeat (4)
    begin
      @(negedge TCbusIf);
      checkNoBus("after EOP", 1'b0);
    end
    @(posedge TCbusIf);
    #5;
    dreq = 4'b0000;
  endtask

  initial
  begin : runAll
    logic [31:0] draw;
    int countSum;
    seed = 40;
    busErrors = 0;
    dackErrors = 0;
    hrqErrors = 0;
    otherErrors = 0;
    tableReady = 1'b0;
    rst = 1'b1;
    cpuBus.csN = 1'b1;
    cpuBus.wrN = 1'b1;
    cpuBus.regAddr = '0;
    cpuBus.data = '0;
    dreq = 4'b0000;
    hlda = 1'b0;
    scenarios[0] = {4'b0001, 2'b00, noSetup,
      makeSetup(0, 16'h1000, 16'd3, dmaRegPkg::writeXfer)};
    scenarios[1] = {4'b0100, 2'b00, noSetup,
      makeSetup(2, 16'h2ffe, 16'd4, dmaRegPkg::readXfer)};
    scenarios[2] = {4'b1000, 2'b00, noSetup,
      makeSetup(3, 16'h00f0, 16'd2, dmaRegPkg::verifyXfer)};
    scenarios[3] = {4'b0110, 2'b00, makeSetup(1, 16'h4000, 16'd2, dmaRegPkg::writeXfer),
      makeSetup(2, 16'h5010, 16'd3, dmaRegPkg::readXfer)};
    scenarios[4] = {4'b1001, 2'b00, makeSetup(0, 16'h0100, 16'd2, dmaRegPkg::verifyXfer),
      makeSetup(3, 16'h7000, 16'd1, dmaRegPkg::readXfer)};
    countSum = 0;
    for (int r = 0; r < numRows; r++)
    begin
      draw = $random(seed);
      scenarios[r].hldaDelay = draw[1:0];
      countSum += int'(scenarios[r].setup[0].count) + int'(scenarios[r].setup[1].count);
    end
    watchdogNs = numRows * (countSum * 8 + 20) * 100;
    tableReady = 1'b1;
    repeat (8) @(posedge TCbusIf);
    #5;
    rst = 1'b0;
    dreq = 4'b1111;  // nothing is programmed yet.
    repeat (10)
    begin
      @(negedge TCbusIf);
      checkNoBus("before any write", 1'b0);
    end
    @(posedge TCbusIf);
    #5;
    dreq = 4'b0000;
    for (int r = 0; r < numRows; r++)
      runScenario(scenarios[r]);
    $display("Error counts: sysBus %0d, dack %0d, hrq %0d, handshake %0d",
      busErrors, dackErrors, hrqErrors, otherErrors);
    if (busErrors + dackErrors + hrqErrors + otherErrors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin : watchdog
    wait (tableReady === 1'b1);
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the run hung.", watchdogNs);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- dmaController.sv
`timescale 1ns/10ps

module dmaController (
  input  logic TCbusIf,
  input  logic rst,
  input  dmaBusPkg::cpuBusT cpuBus,
  input  logic [dmaBusPkg::numChannels-1:0] dreq,
  input  logic hlda,
  output logic hrq,
  output logic [dmaBusPkg::numChannels-1:0] dack,
  output dmaBusPkg::sysBusT sysBus
);

  dmaRegPkg::controlStrobesT ctrl;
  dmaRegPkg::channelStatusT status;
  dmaRegPkg::channelIdxT grantIdx;
  logic grantNow;
  logic [dmaBusPkg::addrWidth-1:0] address;

  dmaRegisterFile dmaRegisterFile_inst (
    .TCbusIf  (TCbusIf),
    .rst      (rst),
    .cpuBus   (cpuBus),
    .ctrl     (ctrl),
    .grantIdx (grantIdx),
    .status   (status),
    .address  (address)
  );

  dmaPriorityLogic dmaPriorityLogic_inst (
    .TCbusIf  (TCbusIf),
    .rst      (rst),
    .dreq     (dreq),
    .grantNow (grantNow),
    .ctrl     (ctrl),
    .grantIdx (grantIdx),
    .dack     (dack)
  );

  // the cycle FSM owns every system-bus pin except dack.
  dmaTimingControl dmaTimingControl_inst (
    .TCbusIf  (TCbusIf),
    .rst      (rst),
    .cpuBus   (cpuBus),
    .dreq     (dreq),
    .hlda     (hlda),
    .status   (status),
    .address  (address),
    .hrq      (hrq),
    .grantNow (grantNow),
    .ctrl     (ctrl),
    .sysBus   (sysBus)
  );

endmodule

//--- dmaTimingControl.sv
`timescale 1ns/10ps

module dmaTimingControl (
  input  logic TCbusIf,
  input  logic rst,
  input  dmaBusPkg::cpuBusT cpuBus,
  input  logic [dmaBusPkg::numChannels-1:0] dreq,
  input  logic hlda,
  input  dmaRegPkg::channelStatusT status,
  input  logic [dmaBusPkg::addrWidth-1:0] address,
  output logic hrq,
  output logic grantNow,
  output dmaRegPkg::controlStrobesT ctrl,
  output dmaBusPkg::sysBusT sysBus
);

  typedef enum int {
    idleBit    = 0,
    requestBit = 1,
    s1Bit      = 2,
    s2Bit      = 3,
    s4Bit      = 4
  } stateBitT;

  typedef enum logic [4:0] {
    idle    = 5'b00001 << idleBit,
    request = 5'b00001 << requestBit,
    S1      = 5'b00001 << s1Bit,
    S2      = 5'b00001 << s2Bit,
    S4      = 5'b00001 << s4Bit
  } stateT;

  stateT state;
  stateT nextState;

  logic configured;
  logic cpuWrite;
  logic programming;
  logic eop;
  logic aen;
  logic ioRead;
  logic ioWrite;
  logic memRead;
  logic memWrite;

  assign cpuWrite = !cpuBus.csN && !cpuBus.wrN;
  assign programming = !cpuBus.csN;  // CPU is still talking to the register port.
  assign eop = state[s4Bit] && status.countZero;

  always_ff @(posedge TCbusIf)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

  // set by any register write, dropped when a channel reaches terminal count.
  always_ff @(posedge TCbusIf)
  begin
    if (rst)
      configured <= 1'b0;
    else if (cpuWrite)
      configured <= 1'b1;
    else if (eop)
      configured <= 1'b0;
  end

  always_comb
  begin
    nextState = state;
    unique case (1'b1)
      state[idleBit]:
      begin
        if (|dreq && configured && !programming)
          nextState = request;
      end
      state[requestBit]:
      begin
        if (hlda)
          nextState = S1;  // waits here for as long as the host holds off.
      end
      state[s1Bit]: nextState = S2;
      state[s2Bit]: nextState = S4;
      state[s4Bit]: nextState = idle;
      default: nextState = idle;
    endcase
  end

  assign grantNow = state[requestBit] && hlda;
  assign hrq = state[requestBit] || state[s1Bit] || state[s2Bit];
  assign aen = state[s1Bit] || state[s2Bit];

  assign ctrl.loadTemp = state[s1Bit];
  assign ctrl.assertDack = aen;
  assign ctrl.decrCount = state[s2Bit];
  assign ctrl.incrAddr = state[s2Bit];
  assign ctrl.updateCurrent = state[s4Bit];

  // data strobes only in S2, chosen by the granted channel's mode.
  always_comb
  begin
    ioRead = 1'b0;
    ioWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    if (state[s2Bit])
    begin
      case (status.activeType)
        dmaRegPkg::writeXfer:
        begin
          ioRead = 1'b1;
          memWrite = 1'b1;
        end
        dmaRegPkg::readXfer:
        begin
          ioWrite = 1'b1;
          memRead = 1'b1;
        end
        default: ;  // verify cycles step the counters silently.
      endcase
    end
  end

  always_comb
  begin
    sysBus.aen = aen;
    sysBus.adstb = state[s1Bit];
    sysBus.iorN = !ioRead;
    sysBus.iowN = !ioWrite;
    sysBus.memrN = !memRead;
    sysBus.memwN = !memWrite;
    sysBus.eopN = !eop;
    sysBus.address = aen ? address : '0;
  end

  stateOneHot: assert property (@(posedge TCbusIf) disable iff (rst)
    $onehot(state))
    else $error("transfer state is not one-hot.");

  ioStrobesExclusive: assert property (@(posedge TCbusIf) disable iff (rst)
    !(!sysBus.iorN && !sysBus.iowN))
    else $error("iorN and iowN low together.");

  // terminal count shows only in the cycle after the bus is given back.
  eopInS4: assert property (@(posedge TCbusIf) disable iff (rst)
    !sysBus.eopN |-> $fell(sysBus.aen) && !hrq)
    else $error("eopN low outside S4.");

endmodule

//--- dmaPriorityLogic.sv
`timescale 1ns/10ps

module dmaPriorityLogic (
  input  logic TCbusIf,
  input  logic rst,
  input  logic [dmaBusPkg::numChannels-1:0] dreq,
  input  logic grantNow,
  input  dmaRegPkg::controlStrobesT ctrl,
  output dmaRegPkg::channelIdxT grantIdx,
  output logic [dmaBusPkg::numChannels-1:0] dack
);

  dmaRegPkg::channelIdxT winner;
  dmaRegPkg::channelIdxT grantReg;
  logic anyReq;

  assign anyReq = |dreq;

  // channel 0 has the highest priority.
  always_comb
  begin
    winner = '0;
    for (int i = dmaBusPkg::numChannels - 1; i >= 0; i--)
    begin
      if (dreq[i])
        winner = dmaRegPkg::channelIdxT'(i);
    end
  end

  always_ff @(posedge TCbusIf)
  begin
    if (rst)
      grantReg <= '0;
    else if (grantNow && anyReq)
      grantReg <= winner;  // held for the whole service cycle.
  end

  assign grantIdx = grantReg;

  always_comb
  begin
    dack = '0;
    if (ctrl.assertDack)
      dack[grantReg] = 1'b1;
  end

  dackOneHot: assert property (@(posedge TCbusIf) disable iff (rst)
    $onehot0(dack))
    else $error("dack is not one-hot or zero.");

endmodule

//--- dmaRegisterFile.sv
`timescale 1ns/10ps

module dmaRegisterFile (
  input  logic TCbusIf,
  input  logic rst,
  input  dmaBusPkg::cpuBusT cpuBus,
  input  dmaRegPkg::controlStrobesT ctrl,
  input  dmaRegPkg::channelIdxT grantIdx,
  output dmaRegPkg::channelStatusT status,
  output logic [dmaBusPkg::addrWidth-1:0] address
);

  dmaRegPkg::channelRegsT chanRegs [dmaBusPkg::numChannels];
  dmaRegPkg::transferTypeT modeRegs [dmaBusPkg::numChannels];

  logic [dmaBusPkg::addrWidth-1:0] tempAddr;
  logic [dmaRegPkg::countWidth-1:0] tempCount;

  logic cpuWrite;
  logic modeWrite;
  logic fieldWrite;
  dmaRegPkg::channelIdxT wrChan;
  dmaRegPkg::channelIdxT modeChan;
  logic [1:0] wrField;
  logic [dmaBusPkg::addrWidth-1:0] newAddr;
  logic [dmaRegPkg::countWidth-1:0] newCount;

  assign cpuWrite = !cpuBus.csN && !cpuBus.wrN;
  assign modeWrite = cpuWrite && cpuBus.regAddr[dmaRegPkg::regModeBit];
  assign fieldWrite = cpuWrite && !cpuBus.regAddr[dmaRegPkg::regModeBit];
  assign wrChan = cpuBus.regAddr[3:2];
  assign wrField = cpuBus.regAddr[1:0];
  assign modeChan = cpuBus.data[1:0];

  // the written byte merges into the base value, the other byte is kept.
  always_comb
  begin
    newAddr = chanRegs[wrChan].baseAddr;
    newCount = chanRegs[wrChan].baseCount;
    case (wrField)
      dmaRegPkg::fieldAddrLow:   newAddr[7:0] = cpuBus.data;
      dmaRegPkg::fieldAddrHigh:  newAddr[15:8] = cpuBus.data;
      dmaRegPkg::fieldCountLow:  newCount[7:0] = cpuBus.data;
      dmaRegPkg::fieldCountHigh: newCount[15:8] = cpuBus.data;
      default: ;
    endcase
  end

  always_ff @(posedge TCbusIf)
  begin
    if (ctrl.updateCurrent)
    begin
      chanRegs[grantIdx].currAddr <= tempAddr;
      chanRegs[grantIdx].currCount <= tempCount;
    end
    // a CPU write lands in both base and current.
    if (fieldWrite)
    begin
      if (!wrField[1]) // fields 0 and 1 are the address bytes.
      begin
        chanRegs[wrChan].baseAddr <= newAddr;
        chanRegs[wrChan].currAddr <= newAddr;
      end
      else
      begin
        chanRegs[wrChan].baseCount <= newCount;
        chanRegs[wrChan].currCount <= newCount;
      end
    end
  end

  always_ff @(posedge TCbusIf)
  begin
    if (rst)
    begin
      for (int i = 0; i < dmaBusPkg::numChannels; i++)
        modeRegs[i] <= dmaRegPkg::verifyXfer;
    end
    else if (modeWrite)
      modeRegs[modeChan] <= dmaRegPkg::transferTypeT'(cpuBus.data[3:2]);
  end

  // working copies of the granted channel for the cycle in flight.
  always_ff @(posedge TCbusIf)
  begin
    if (ctrl.loadTemp)
    begin
      tempAddr <= chanRegs[grantIdx].currAddr;
      tempCount <= chanRegs[grantIdx].currCount;
    end
    else
    begin
      if (ctrl.incrAddr)
        tempAddr <= tempAddr + 1'b1;
      if (ctrl.decrCount)
        tempCount <= tempCount - 1'b1;
    end
  end

  assign status.activeType = modeRegs[grantIdx];
  assign status.countZero = (tempCount == '0);

  // the temporaries are only loaded at the end of S1, so S1 shows current.
  assign address = ctrl.loadTemp ? chanRegs[grantIdx].currAddr : tempAddr;

  // write-back happens in S4, copying in S1, and the two never overlap.
  loadUpdateExclusive: assert property (@(posedge TCbusIf) disable iff (rst)
    !(ctrl.loadTemp && ctrl.updateCurrent))
    else $error("loadTemp and updateCurrent high together.");

endmodule

//--- dmaRegPkg.sv
package dmaRegPkg;

  localparam int countWidth = 16;

  typedef logic [1:0] channelIdxT;

  // verify steps address and count but moves no data.
  typedef enum logic [1:0] {
    verifyXfer = 2'd0,
    writeXfer  = 2'd1,  // I/O read into memory.
    readXfer   = 2'd2   // memory read out to I/O.
  } transferTypeT;

  // register map. bit 4 high selects a mode write, otherwise bits 3:2
  // pick the channel and bits 1:0 the byte below.
  localparam int regModeBit = 4;
  localparam logic [1:0] fieldAddrLow = 2'd0;
  localparam logic [1:0] fieldAddrHigh = 2'd1;
  localparam logic [1:0] fieldCountLow = 2'd2;
  localparam logic [1:0] fieldCountHigh = 2'd3;

  typedef struct packed {
    logic [dmaBusPkg::addrWidth-1:0] baseAddr;
    logic [dmaBusPkg::addrWidth-1:0] currAddr;
    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] currCount;
  } channelRegsT;

  // strobes from the cycle FSM into the register file and arbiter.
  typedef struct packed {
    logic loadTemp;
    logic assertDack;
    logic decrCount;
    logic incrAddr;
    logic updateCurrent;
  } controlStrobesT;

  typedef struct packed {
    transferTypeT activeType;
    logic countZero;    // temporary count has run out.
  } channelStatusT;

endpackage

//--- dmaBusPkg.sv
package dmaBusPkg;

  // number of request/acknowledge channel pairs.
  localparam int numChannels = 4;

  localparam int addrWidth = 16;
  localparam int dataWidth = 8;
  localparam int regAddrWidth = 5;

  // one access from the CPU to the register port.
  typedef struct packed {
    logic csN;                        // active-low chip select.
    logic wrN;                        // active-low write strobe.
    logic [regAddrWidth-1:0] regAddr;
    logic [dataWidth-1:0] data;
  } cpuBusT;

  // system-bus pins driven while the controller owns the bus.
  typedef struct packed {
    logic aen;
    logic adstb;
    logic iorN;
    logic iowN;
    logic memrN;
    logic memwN;
    logic eopN;
    logic [addrWidth-1:0] address;
  } sysBusT;

endpackage
